//--- Bender.yml
package:
  name: keypad_lock

sources:
  - source/lock_pkg.sv
  - source/key_decoder.sv
  - source/code_lock.sv
  - source/buzzer_driver.sv
  - source/display_driver.sv
  - source/lock_top.sv
  - target: simulation
    files:
      - sim/lock_checker.sv
      - sim/tb_lock.sv

//--- sim/lock_checker.sv
`timescale 1ns/1ps
`default_nettype none

module lock_checker import lock_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  logic [15:0]  onehot,
    input  seg_t         seg0,
    input  seg_t         seg1,
    input  seg_t         seg2,
    input  seg_t         seg3,
    input  logic         buzzer,
    input  lock_state_t  state,
    input  attempt_t     attempts,
    input  digit_count_t digit_count,
    input  logic         strobe,
    input  lock_state_t  exp_state,
    input  attempt_t     exp_attempts,
    output int           value_errors,
    output int           buzzer_errors
);

    lock_state_t m_state;     // reference model of the lock
    int          m_att;
    int          m_cnt;
    code_word_t  m_digits;
    logic [15:0] prev_lines;  // keypad lines seen one cycle earlier
    logic        tone_on;
    int          tone_start;  // cycle on which buzzer should rise
    int          tone_len;
    logic        tone_pending;  // request seen but tone not started yet
    int          pend_start;
    int          pend_len;
    int          cyc;

    initial begin
        value_errors  = 0;
        buzzer_errors = 0;
        cyc           = 0;
    end

    always @(posedge clk) cyc <= cyc + 1;

    // keypad wiring with -1 for lines that carry no key
    function automatic int key_of(input logic [15:0] lines);
        case (lines)
            16'h0008: return 0;
            16'h0080: return 1;
            16'h0040: return 2;
            16'h0020: return 3;
            16'h0800: return 4;
            16'h0400: return 5;
            16'h0200: return 6;
            16'h8000: return 7;
            16'h4000: return 8;
            16'h2000: return 9;
            16'h0001: return int'(key_enter);
            16'h0100: return int'(key_clear);
            16'h1000: return int'(key_cancel);
            default:  return -1;
        endcase
    endfunction

    // segments a..g on bits 0..6
    function automatic seg_t digit_pattern(input logic [3:0] d);
        case (d)
            4'd0:    return 7'h3F;
            4'd1:    return 7'h06;
            4'd2:    return 7'h5B;
            4'd3:    return 7'h4F;
            4'd4:    return 7'h66;
            4'd5:    return 7'h6D;
            4'd6:    return 7'h7D;
            4'd7:    return 7'h07;
            4'd8:    return 7'h7F;
            default: return 7'h6F;
        endcase
    endfunction

    function automatic seg_t expected_seg(input int pos);
        if (m_state == st_open) begin
            return (pos == 3) ? 7'h73 : (pos == 2) ? 7'h77 : 7'h6D;  // P A S S
        end else if (m_state == st_locked) begin
            return digit_pattern(4'd0);
        end
        return (pos < m_cnt) ? digit_pattern(m_digits[pos*4 +: 4]) : 7'h00;
    endfunction

    task automatic start_tone(input int len);
        tone_pending = 1'b1;
        pend_start   = cyc + 3;  // decoder, lock and buzzer stages
        pend_len     = len;
    endtask

    task automatic apply_key(input int code);
        if (code == int'(key_clear)) begin
            m_state = st_entry;
            m_att   = 0;
            m_cnt   = 0;
        end else if (m_state == st_entry) begin
            if (code <= 9) begin
                if (m_cnt < int'(code_digits)) begin
                    m_digits = {m_digits[7:0], code[3:0]};
                    m_cnt    = m_cnt + 1;
                    start_tone(chirp_cycles);
                end
            end else if (code == int'(key_enter) && m_cnt == int'(code_digits)) begin
                if (m_digits == secret_code) begin
                    m_state = st_open;
                    start_tone(success_cycles);
                end else begin
                    m_cnt = 0;
                    m_att = m_att + 1;
                    if (m_att == int'(max_tries)) m_state = st_locked;
                end
            end else if (code == int'(key_cancel)) begin
                m_cnt = 0;
            end
        end else if (m_state == st_open && code == int'(key_cancel)) begin
            m_state = st_entry;
            m_cnt   = 0;
        end
    endtask

    task automatic compare_value(input string name, input logic [15:0] got,
                                 input logic [15:0] exp);
        if (got !== exp) begin
            value_errors = value_errors + 1;
            $display("ERROR t=%0t %s: got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin : watch
        int   k;
        int   code;
        logic buzz_exp;
        if (!rst_n) begin
            m_state      = st_entry;
            m_att        = 0;
            m_cnt        = 0;
            m_digits     = '0;
            prev_lines   = '0;
            tone_on      = 1'b0;
            tone_pending = 1'b0;
        end else begin
            if (strobe) begin  // compare before this cycle's press enters the model
                compare_value("state", state, exp_state);
                compare_value("attempts", attempts, exp_attempts);
                compare_value("digit_count", digit_count, m_cnt);
                compare_value("seg0", seg0, expected_seg(0));
                compare_value("seg1", seg1, expected_seg(1));
                compare_value("seg2", seg2, expected_seg(2));
                compare_value("seg3", seg3, expected_seg(3));
            end
            if (tone_pending && cyc >= pend_start) begin  // old tone runs until here
                tone_on      = 1'b1;
                tone_start   = pend_start;
                tone_len     = pend_len;
                tone_pending = 1'b0;
            end
            buzz_exp = 1'b0;
            k        = cyc - tone_start;
            if (tone_on && k >= 0 && k < tone_len) begin
                buzz_exp = ((k / int'(tone_half_cycles)) % 2) == 0;  // high half first
            end
            if (buzzer !== buzz_exp) begin
                buzzer_errors = buzzer_errors + 1;
                $display("ERROR t=%0t buzzer: got %b expected %b", $time, buzzer, buzz_exp);
            end
            code = key_of(onehot);
            if (prev_lines == '0 && code >= 0) apply_key(code);  // new press only
            prev_lines = onehot;
        end
    end

endmodule

`default_nettype wire

//--- sim/tb_lock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_lock import lock_pkg::*; ();

    logic         clk;
    logic         rst_n;
    logic [15:0]  onehot;
    seg_t         seg0;
    seg_t         seg1;
    seg_t         seg2;
    seg_t         seg3;
    logic         buzzer;
    lock_state_t  state;
    attempt_t     attempts;
    digit_count_t digit_count;
    logic         strobe;
    lock_state_t  exp_state;
    attempt_t     exp_attempts;
    int           value_errors;
    int           buzzer_errors;
    logic         table_ready;

    logic [15:0]  step_key[$];  // all zero means a long idle gap
    lock_state_t  step_state[$];
    attempt_t     step_att[$];
    int           i;
    int           a;

    lock_top dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .onehot      (onehot),
        .seg0        (seg0),
        .seg1        (seg1),
        .seg2        (seg2),
        .seg3        (seg3),
        .buzzer      (buzzer),
        .state       (state),
        .attempts    (attempts),
        .digit_count (digit_count)
    );

    lock_checker u_checker (
        .clk           (clk),
        .rst_n         (rst_n),
        .onehot        (onehot),
        .seg0          (seg0),
        .seg1          (seg1),
        .seg2          (seg2),
        .seg3          (seg3),
        .buzzer        (buzzer),
        .state         (state),
        .attempts      (attempts),
        .digit_count   (digit_count),
        .strobe        (strobe),
        .exp_state     (exp_state),
        .exp_attempts  (exp_attempts),
        .value_errors  (value_errors),
        .buzzer_errors (buzzer_errors)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // keypad line for a digit or command key
    function automatic logic [15:0] key_line(input int k);
        case (k)
            0:       return 16'h0008;
            1:       return 16'h0080;
            2:       return 16'h0040;
            3:       return 16'h0020;
            4:       return 16'h0800;
            5:       return 16'h0400;
            6:       return 16'h0200;
            7:       return 16'h8000;
            8:       return 16'h4000;
            9:       return 16'h2000;
            10:      return 16'h0001;  // enter
            11:      return 16'h0100;  // clear
            default: return 16'h1000;  // cancel
        endcase
    endfunction

    task automatic add_step(input logic [15:0] key, input lock_state_t st, input int att);
        step_key.push_back(key);
        step_state.push_back(st);
        step_att.push_back(attempt_t'(att));
    endtask

    task automatic build_table();
        add_step(key_line(1), st_entry, 0);
        add_step(key_line(3), st_entry, 0);
        add_step(key_line(3), st_entry, 0);           // repeated digit
        add_step(key_line(3), st_entry, 0);           // fourth digit dropped
        add_step(key_line(key_cancel), st_entry, 0);
        add_step(key_line(7), st_entry, 0);
        add_step(16'h0002, st_entry, 0);              // unmapped lines
        add_step(16'h0004, st_entry, 0);
        add_step(16'h0010, st_entry, 0);
        add_step(16'h0088, st_entry, 0);              // two keys at once
        add_step(key_line(key_enter), st_entry, 0);   // short code
        add_step(key_line(1), st_entry, 0);
        add_step(key_line(2), st_entry, 0);
        add_step(key_line(3), st_entry, 0);
        add_step(key_line(key_enter), st_entry, 1);   // 712 is wrong
        add_step(key_line(2), st_entry, 1);
        add_step(key_line(4), st_entry, 1);
        add_step(key_line(6), st_entry, 1);
        add_step(key_line(key_enter), st_open, 1);
        add_step(16'h0000, st_open, 1);               // let the success tone end
        add_step(key_line(5), st_open, 1);
        add_step(key_line(key_cancel), st_entry, 1);
        add_step(key_line(key_clear), st_entry, 0);
        for (a = 0; a < 6; a++) begin
            add_step(key_line(9), st_entry, a);
            add_step(key_line(9), st_entry, a);
            add_step(key_line(9), st_entry, a);
            add_step(key_line(key_enter), (a == 5) ? st_locked : st_entry, a + 1);
        end
        add_step(key_line(2), st_locked, 6);          // nothing but clear works now
        add_step(key_line(4), st_locked, 6);
        add_step(key_line(6), st_locked, 6);
        add_step(key_line(key_enter), st_locked, 6);
        add_step(key_line(key_cancel), st_locked, 6);
        add_step(key_line(1), st_locked, 6);
        add_step(16'h0002, st_locked, 6);
        add_step(16'h0088, st_locked, 6);
        add_step(key_line(key_cancel), st_locked, 6);
        add_step(key_line(3), st_locked, 6);
        add_step(key_line(key_clear), st_entry, 0);
        add_step(key_line(2), st_entry, 0);
    endtask

    // watchdog sized from the table
    initial begin
        wait (table_ready === 1'b1);
        repeat (step_key.size() * 6 + success_cycles + 200) @(posedge clk);
        $display("timeout: the stimulus table did not finish in time");
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        onehot       = '0;
        rst_n        = 1'b0;
        strobe       = 1'b0;
        exp_state    = st_entry;
        exp_attempts = '0;
        table_ready  = 1'b0;
        build_table();
        table_ready = 1'b1;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        for (i = 0; i < step_key.size(); i++) begin
            onehot <= step_key[i];  // press held 2 cycles
            @(posedge clk);
            strobe <= 1'b0;
            if (step_key[i] == '0) begin
                repeat (success_cycles + 8) @(posedge clk);
            end
            @(posedge clk);
            onehot <= '0;  // released 4 cycles
            repeat (4) @(posedge clk);
            exp_state    <= step_state[i];
            exp_attempts <= step_att[i];
            strobe       <= 1'b1;
        end
        @(posedge clk);
        strobe <= 1'b0;
        repeat (2) @(posedge clk);
        $display("closing report: %0d value errors, %0d buzzer errors",
                 value_errors, buzzer_errors);
        if (value_errors == 0 && buzzer_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- source/buzzer_driver.sv
`timescale 1ns/1ps
`default_nettype none

module buzzer_driver import lock_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic chirp,
    input  logic success,
    output logic buzzer
);

    duration_t                              dur_cnt;   // cycles left in the tone
    logic [$clog2(tone_half_cycles)-1:0]    half_cnt;  // cycles left in the half period

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dur_cnt  <= '0;
            half_cnt <= '0;
            buzzer   <= 1'b0;
        end else begin
            if (success || chirp) begin
                // success wins, a new request restarts the tone
                if (success) begin
                    dur_cnt <= duration_t'(success_cycles);
                end else begin
                    dur_cnt <= duration_t'(chirp_cycles);
                end
                half_cnt <= $bits(half_cnt)'(tone_half_cycles - 1);
                buzzer   <= 1'b1;
            end else if (dur_cnt != '0) begin
                dur_cnt <= dur_cnt - 1'b1;
                if (dur_cnt == duration_t'(1)) begin
                    buzzer <= 1'b0;  // end of tone
                end else if (half_cnt == '0) begin
                    buzzer   <= ~buzzer;
                    half_cnt <= $bits(half_cnt)'(tone_half_cycles - 1);
                end else begin
                    half_cnt <= half_cnt - 1'b1;
                end
            end
        end
    end

    // silence outside the tone window
    assert property (@(posedge clk) disable iff (!rst_n) (dur_cnt == '0) |-> !buzzer)
        else $error("buzzer high while duration counter idle");

endmodule

`default_nettype wire

//--- source/code_lock.sv
`timescale 1ns/1ps
`default_nettype none

module code_lock import lock_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         key_valid,
    input  key_code_t    key_code,
    output lock_state_t  state,
    output code_word_t   digits,
    output digit_count_t digit_count,
    output attempt_t     attempts,
    output logic         chirp,
    output logic         success
);

    attempt_t attempts_next;
    logic     is_digit;

    assign attempts_next = attempts + 3'd1;
    assign is_digit      = (key_code <= 4'd9);  // digits sit below the commands

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= st_entry;
            digits      <= '1;  // all nibbles blank
            digit_count <= '0;
            attempts    <= '0;
            chirp       <= 1'b0;
            success     <= 1'b0;
        end else begin
            chirp   <= 1'b0;  // pulses last one cycle
            success <= 1'b0;
            if (key_valid) begin
                if (key_code == key_clear) begin
                    // full reset of the lock from any state
                    state       <= st_entry;
                    digits      <= '1;
                    digit_count <= '0;
                    attempts    <= '0;
                end else begin
                    case (state)
                        st_entry: begin
                            if (is_digit) begin
                                if (digit_count < code_digits) begin
                                    digits      <= {digits[7:0], key_code};  // shift in from right
                                    digit_count <= digit_count + 2'd1;
                                    chirp       <= 1'b1;
                                end
                            end else if (key_code == key_enter) begin
                                if (digit_count == code_digits) begin  // short codes ignored
                                    if (digits == secret_code) begin
                                        state   <= st_open;
                                        success <= 1'b1;
                                    end else begin
                                        digits      <= '1;
                                        digit_count <= '0;
                                        attempts    <= attempts_next;
                                        if (attempts_next == max_tries) begin
                                            state <= st_locked;
                                        end
                                    end
                                end
                            end else if (key_code == key_cancel) begin
                                digits      <= '1;
                                digit_count <= '0;
                            end
                        end
                        st_open: begin
                            if (key_code == key_cancel) begin
                                state       <= st_entry;
                                digits      <= '1;
                                digit_count <= '0;
                            end
                        end
                        default: begin
                            // locked, only clear gets out
                        end
                    endcase
                end
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) attempts <= max_tries)
        else $error("attempts above max_tries");

    assert property (@(posedge clk) disable iff (!rst_n) digit_count <= code_digits)
        else $error("digit_count above code_digits");

endmodule

`default_nettype wire

//--- source/display_driver.sv
`timescale 1ns/1ps
`default_nettype none

module display_driver import lock_pkg::*; (
    input  lock_state_t  state,
    input  code_word_t   digits,
    input  digit_count_t digit_count,
    output seg_t         seg0,
    output seg_t         seg1,
    output seg_t         seg2,
    output seg_t         seg3
);

    function automatic seg_t digit_seg(input key_code_t d);
        case (d)
            4'd0:    return 7'h3F;
            4'd1:    return 7'h06;
            4'd2:    return 7'h5B;
            4'd3:    return 7'h4F;
            4'd4:    return 7'h66;
            4'd5:    return 7'h6D;
            4'd6:    return 7'h7D;
            4'd7:    return 7'h07;
            4'd8:    return 7'h7F;
            4'd9:    return 7'h6F;
            default: return seg_blank;
        endcase
    endfunction

    always_comb begin
        seg0 = seg_blank;
        seg1 = seg_blank;
        seg2 = seg_blank;
        seg3 = seg_blank;  // leftmost stays dark during entry
        case (state)
            st_entry: begin
                // right-aligned, newest digit on seg0
                if (digit_count >= 2'd1) seg0 = digit_seg(digits[3:0]);
                if (digit_count >= 2'd2) seg1 = digit_seg(digits[7:4]);
                if (digit_count >= 2'd3) seg2 = digit_seg(digits[11:8]);
            end
            st_open: begin
                seg3 = seg_p;
                seg2 = seg_a;
                seg1 = seg_s;
                seg0 = seg_s;
            end
            st_locked: begin
                seg3 = digit_seg(4'd0);
                seg2 = digit_seg(4'd0);
                seg1 = digit_seg(4'd0);
                seg0 = digit_seg(4'd0);
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- source/key_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module key_decoder import lock_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [15:0] onehot,
    output logic        key_valid,
    output key_code_t   key_code
);

    logic [15:0] onehot_q;  // last sampled keypad lines
    logic        key_hit;   // current input is a mapped single key
    key_code_t   key_next;

    // keypad layout, one line per key
    always_comb begin
        key_hit  = 1'b1;
        key_next = key_enter;
        case (onehot)
            16'h0008: key_next = 4'd0;
            16'h0080: key_next = 4'd1;
            16'h0040: key_next = 4'd2;
            16'h0020: key_next = 4'd3;
            16'h0800: key_next = 4'd4;
            16'h0400: key_next = 4'd5;
            16'h0200: key_next = 4'd6;
            16'h8000: key_next = 4'd7;
            16'h4000: key_next = 4'd8;
            16'h2000: key_next = 4'd9;
            16'h0001: key_next = key_enter;
            16'h0100: key_next = key_clear;
            16'h1000: key_next = key_cancel;
            default:  key_hit  = 1'b0;  // unmapped or several lines
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            onehot_q  <= '0;
            key_valid <= 1'b0;
        end else begin
            onehot_q  <= onehot;
            key_valid <= key_hit && (onehot_q == '0);  // idle to press only
        end
    end

    always_ff @(posedge clk) begin
        if (key_hit && (onehot_q == '0)) begin
            key_code <= key_next;
        end
    end

    // a held key must never repeat the strobe
    assert property (@(posedge clk) disable iff (!rst_n) key_valid |=> !key_valid)
        else $error("key_valid high in two consecutive cycles");

endmodule

`default_nettype wire

//--- source/lock_pkg.sv
`default_nettype none

package lock_pkg;

    typedef logic [3:0]  key_code_t;     // digits 0 to 9 then command keys
    typedef logic [11:0] code_word_t;    // newest digit in low nibble
    typedef logic [2:0]  attempt_t;      // failed tries
    typedef logic [1:0]  digit_count_t;  // digits entered so far
    typedef logic [6:0]  seg_t;          // active high with segment a on bit 0
    typedef logic [8:0]  duration_t;     // buzzer tone length in cycles

    typedef enum logic [1:0] {
        st_entry,
        st_open,
        st_locked
    } lock_state_t;

    // command keys above the digit range
    localparam key_code_t key_enter  = 4'hA;
    localparam key_code_t key_clear  = 4'hB;
    localparam key_code_t key_cancel = 4'hC;

    localparam code_word_t   secret_code = 12'h246;
    localparam digit_count_t code_digits = 2'd3;
    localparam attempt_t     max_tries   = 3'd6;

    // buzzer timing scaled down for simulation
    localparam int unsigned tone_half_cycles = 4;
    localparam int unsigned chirp_cycles     = 64;
    localparam int unsigned success_cycles   = 256;

    // letter patterns for the status display
    localparam seg_t seg_blank = 7'h00;
    localparam seg_t seg_p     = 7'h73;
    localparam seg_t seg_a     = 7'h77;
    localparam seg_t seg_s     = 7'h6D;  // same shape as digit 5

endpackage

`default_nettype wire

//--- source/lock_top.sv
`timescale 1ns/1ps
`default_nettype none

module lock_top import lock_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  logic [15:0]  onehot,
    output seg_t         seg0,
    output seg_t         seg1,
    output seg_t         seg2,
    output seg_t         seg3,
    output logic         buzzer,
    output lock_state_t  state,
    output attempt_t     attempts,
    output digit_count_t digit_count
);

    logic       key_valid;
    key_code_t  key_code;
    code_word_t digits;
    logic       chirp;
    logic       success;

    key_decoder u_key_decoder (
        .clk       (clk),
        .rst_n     (rst_n),
        .onehot    (onehot),
        .key_valid (key_valid),
        .key_code  (key_code)
    );

    code_lock u_code_lock (
        .clk         (clk),
        .rst_n       (rst_n),
        .key_valid   (key_valid),
        .key_code    (key_code),
        .state       (state),
        .digits      (digits),
        .digit_count (digit_count),
        .attempts    (attempts),
        .chirp       (chirp),
        .success     (success)
    );

    buzzer_driver u_buzzer_driver (
        .clk     (clk),
        .rst_n   (rst_n),
        .chirp   (chirp),
        .success (success),
        .buzzer  (buzzer)
    );

    display_driver u_display_driver (
        .state       (state),
        .digits      (digits),
        .digit_count (digit_count),
        .seg0        (seg0),
        .seg1        (seg1),
        .seg2        (seg2),
        .seg3        (seg3)
    );

endmodule

`default_nettype wire

//--- verilog.f
source/lock_pkg.sv
source/key_decoder.sv
source/code_lock.sv
source/buzzer_driver.sv
source/display_driver.sv
source/lock_top.sv
sim/lock_checker.sv
sim/tb_lock.sv
